//--- build.f
+incdir+test
verilog/gpio_pkg.sv
verilog/gpio_apb_slave.sv
verilog/gpio_lite_subunit.sv
verilog/gpio_lite.sv
test/tb_gpio_lite.sv

//--- test/tb_gpio_tasks.svh
//----------------------------
// gpio testbench helpers
// apb transfer tasks, value checks
// and the error counters
//----------------------------
`ifndef TB_GPIO_TASKS_SVH
`define TB_GPIO_TASKS_SVH

int error_count = 0;  // failed checks
int check_count = 0;  // all checks run

// n rising edges, then land on the drive point
task automatic step_cycles(input int n);
  repeat (n) @(posedge pclk25);
  #1;
endtask

// compare one value, report on mismatch
task automatic check_value(
  input string       test_name,
  input string       what,
  input logic [31:0] expected,
  input logic [31:0] actual
);
  check_count++;
  assert (actual === expected)
  else
  begin
    error_count++;
    $display("FAILED %s %s expected 0x%0h actual 0x%0h",
             test_name, what, expected, actual);
  end
endtask

//----------------------------
// apb transfers
//----------------------------
// called on the drive point, returns on the drive point
task automatic apb_write(
  input  logic [gpio_pkg::addr_width-1:0] addr,
  input  logic [gpio_pkg::gpio_width-1:0] data,
  output logic                            err
);
  psel    = 1'b1;   // setup cycle
  penable = 1'b0;
  pwrite  = 1'b1;
  paddr   = addr;
  pwdata  = data;
  @(posedge pclk25);
  #1;
  penable = 1'b1;   // access cycle
  @(negedge pclk25);
  err = pslverr;    // stable mid access
  @(posedge pclk25);
  #1;
  psel    = 1'b0;   // back to idle
  penable = 1'b0;
  pwrite  = 1'b0;
endtask

task automatic apb_read(
  input  logic [gpio_pkg::addr_width-1:0] addr,
  output logic [gpio_pkg::gpio_width-1:0] data,
  output logic                            err
);
  psel    = 1'b1;
  penable = 1'b0;
  pwrite  = 1'b0;
  paddr   = addr;
  @(posedge pclk25);
  #1;
  penable = 1'b1;
  @(negedge pclk25);
  data = prdata;    // rdata registered at end of setup
  err  = pslverr;
  @(posedge pclk25);
  #1;
  psel    = 1'b0;
  penable = 1'b0;
endtask

`endif

//--- test/tb_gpio_lite.sv
//----------------------------
// gpio lite testbench
// directed tests against a register model
//----------------------------
`default_nettype none

module tb_gpio_lite;

  // tests need roughly 400 cycles, five times that as margin
  localparam int timeout_cycles = 2000;

  logic                            pclk25;
  logic                            n_reset25;
  logic                            psel;
  logic                            penable;
  logic                            pwrite;
  logic [gpio_pkg::addr_width-1:0] paddr;
  logic [gpio_pkg::gpio_width-1:0] pwdata;
  logic [gpio_pkg::gpio_width-1:0] prdata;
  logic                            pslverr;
  logic [gpio_pkg::gpio_width-1:0] pin_in;
  logic [gpio_pkg::gpio_width-1:0] tri_state_enable;
  gpio_pkg::gpio_pad_t             pad;
  logic [gpio_pkg::gpio_width-1:0] interrupt;

  integer seed = 38;  // fixed for repeatable runs
  int     cycle_count = 0;

  // register model
  logic [gpio_pkg::gpio_width-1:0] model_direction;
  logic [gpio_pkg::gpio_width-1:0] model_enable;
  logic [gpio_pkg::gpio_width-1:0] model_value;
  logic [gpio_pkg::gpio_width-1:0] model_status;

  `include "tb_gpio_tasks.svh"

  gpio_lite dut0 (
    .pclk25           (pclk25),
    .n_reset25        (n_reset25),
    .psel             (psel),
    .penable          (penable),
    .pwrite           (pwrite),
    .paddr            (paddr),
    .pwdata           (pwdata),
    .prdata           (prdata),
    .pslverr          (pslverr),
    .pin_in           (pin_in),
    .tri_state_enable (tri_state_enable),
    .pad              (pad),
    .interrupt        (interrupt)
  );

  initial
  begin
    pclk25 = 1'b0;
    forever #5 pclk25 = ~pclk25;  // period 10
  end

  // run limit
  initial
  begin
    while (cycle_count < timeout_cycles)
    begin
      @(posedge pclk25);
      cycle_count++;
    end
    $display("timeout: tests did not finish within %0d cycles", timeout_cycles);
    $display("=== FAIL ===");
    $finish;
  end

  // write all three control registers and the model
  task automatic write_controls(input logic [15:0] dir, input logic [15:0] oe,
                                input logic [15:0] out);
    logic err;
    apb_write(gpio_pkg::gpr_direction_mode, dir, err);
    apb_write(gpio_pkg::gpr_output_enable, oe, err);
    apb_write(gpio_pkg::gpr_output_value, out, err);
    model_direction = dir;
    model_enable    = oe;
    model_value     = out;
  endtask

  //----------------------------
  // tests
  //----------------------------
  task automatic test_reset_readback();
    logic [15:0] data;
    logic [15:0] wval;
    logic        err;
    @(negedge pclk25);
    check_value("reset", "pin_oe_n", 16'hFFFF, pad.pin_oe_n);  // drivers off
    check_value("reset", "pin_out", 16'h0000, pad.pin_out);
    check_value("reset", "interrupt", 16'h0000, interrupt);
    check_value("reset", "prdata", 16'h0000, prdata);
    check_value("reset", "pslverr", 1'b0, pslverr);
    step_cycles(1);
    apb_read(gpio_pkg::gpr_direction_mode, data, err);
    check_value("reset", "direction", 16'h0000, data);
    apb_read(gpio_pkg::gpr_output_enable, data, err);
    check_value("reset", "output enable", 16'h0000, data);
    apb_read(gpio_pkg::gpr_output_value, data, err);
    check_value("reset", "output value", 16'h0000, data);
    apb_read(gpio_pkg::gpr_int_status, data, err);
    check_value("reset", "int status", 16'h0000, data);
    for (int i = 0; i < 8; i++)
    begin
      wval = $random(seed);
      apb_write(gpio_pkg::gpr_direction_mode, wval, err);
      check_value("readback", "write pslverr", 1'b0, err);
      apb_read(gpio_pkg::gpr_direction_mode, data, err);
      check_value("readback", "direction", wval, data);
      check_value("readback", "read pslverr", 1'b0, err);
      wval = $random(seed);
      apb_write(gpio_pkg::gpr_output_enable, wval, err);
      check_value("readback", "enable write pslverr", 1'b0, err);
      apb_read(gpio_pkg::gpr_output_enable, data, err);
      check_value("readback", "output enable", wval, data);
      wval = $random(seed);
      apb_write(gpio_pkg::gpr_output_value, wval, err);
      check_value("readback", "value write pslverr", 1'b0, err);
      apb_read(gpio_pkg::gpr_output_value, data, err);
      check_value("readback", "output value", wval, data);
    end
  endtask

  task automatic test_pad_drive();
    logic [15:0] tse;
    logic [15:0] expected_oe_n;
    for (int i = 0; i < 8; i++)
    begin
      write_controls($random(seed), $random(seed), $random(seed));
      tse = $random(seed);
      tri_state_enable = tse;
      // drives only as enabled output outside test mode
      expected_oe_n = ~(model_enable & ~model_direction & ~tse);
      @(negedge pclk25);
      check_value("pad_drive", "pin_out", model_value, pad.pin_out);
      check_value("pad_drive", "pin_oe_n", expected_oe_n, pad.pin_oe_n);
      step_cycles(1);
    end
    tri_state_enable = '0;
  endtask

  task automatic test_input_sampling();
    logic [15:0] data;
    logic        err;
    for (int i = 0; i < 6; i++)
    begin
      pin_in = $random(seed);
      step_cycles(4);  // three edges through the synchroniser
      apb_read(gpio_pkg::gpr_input_value, data, err);
      check_value("input_sampling", "input value", pin_in, data);
      check_value("input_sampling", "pslverr", 1'b0, err);
      apb_read(6'h3C, data, err);  // hole in the map
      check_value("input_sampling", "unmapped read", pin_in, data);
      check_value("input_sampling", "unmapped pslverr", 1'b1, err);
    end
  endtask

  task automatic test_edge_interrupt();
    logic [15:0] mask;
    logic [15:0] rise;
    logic [15:0] data;
    logic        err;
    mask = ($random(seed) | 16'h0001) & 16'h7FFF;  // pin 15 stays output
    rise = $random(seed) | 16'h8001;
    pin_in = '0;
    step_cycles(4);
    apb_write(gpio_pkg::gpr_direction_mode, mask, err);
    model_direction = mask;
    apb_read(gpio_pkg::gpr_int_status, data, err);  // drop old flags
    @(negedge pclk25);
    check_value("edge_interrupt", "cleared", 16'h0000, interrupt);
    step_cycles(1);
    pin_in = rise;
    step_cycles(4);  // flag lands on the third edge
    @(negedge pclk25);
    check_value("edge_interrupt", "rising", rise & mask, interrupt);
    step_cycles(1);
    pin_in = '0;     // falling edges only
    step_cycles(4);
    @(negedge pclk25);
    check_value("edge_interrupt", "falling", rise & mask, interrupt);
    step_cycles(1);
    model_status = rise & mask;
  endtask

  task automatic test_read_clear();
    logic [15:0] data;
    logic        err;
    apb_read(gpio_pkg::gpr_int_status, data, err);
    check_value("read_clear", "first read", model_status, data);
    check_value("read_clear", "pslverr", 1'b0, err);
    @(negedge pclk25);
    check_value("read_clear", "interrupt", 16'h0000, interrupt);
    step_cycles(1);
    apb_read(gpio_pkg::gpr_int_status, data, err);
    check_value("read_clear", "second read", 16'h0000, data);
    model_status = '0;
  endtask

  task automatic test_bus_errors();
    logic [5:0]  holes [4];
    logic [15:0] data;
    logic        err;
    holes = '{6'h00, 6'h06, 6'h14, 6'h3C};
    foreach (holes[i])
    begin
      apb_write(holes[i], $random(seed), err);
      check_value("bus_errors", "unmapped write", 1'b1, err);
      apb_read(holes[i], data, err);
      check_value("bus_errors", "unmapped read", 1'b1, err);
    end
    apb_write(gpio_pkg::gpr_input_value, $random(seed), err);
    check_value("bus_errors", "input value write", 1'b1, err);
    apb_write(gpio_pkg::gpr_int_status, 16'hFFFF, err);
    check_value("bus_errors", "int status write", 1'b1, err);
    apb_read(gpio_pkg::gpr_int_status, data, err);
    check_value("bus_errors", "int status", model_status, data);
    check_value("bus_errors", "int status pslverr", 1'b0, err);
    // nothing above may touch the control registers
    apb_read(gpio_pkg::gpr_direction_mode, data, err);
    check_value("bus_errors", "direction", model_direction, data);
    check_value("bus_errors", "valid pslverr", 1'b0, err);
    apb_read(gpio_pkg::gpr_output_enable, data, err);
    check_value("bus_errors", "output enable", model_enable, data);
    apb_read(gpio_pkg::gpr_output_value, data, err);
    check_value("bus_errors", "output value", model_value, data);
    check_value("bus_errors", "interrupt", 16'h0000, interrupt);
  endtask

  //----------------------------
  // main sequence
  //----------------------------
  initial
  begin
    n_reset25        = 1'b0;
    psel             = 1'b0;
    penable          = 1'b0;
    pwrite           = 1'b0;
    paddr            = '0;
    pwdata           = '0;
    pin_in           = '0;
    tri_state_enable = '0;
    model_direction  = gpio_pkg::gprv_direction_mode;
    model_enable     = gpio_pkg::gprv_output_enable;
    model_value      = gpio_pkg::gprv_output_value;
    model_status     = gpio_pkg::gprv_int_status;
    repeat (8) @(posedge pclk25);
    #1;
    n_reset25 = 1'b1;  // released on a drive point
    test_reset_readback();
    test_pad_drive();
    test_input_sampling();
    test_edge_interrupt();
    test_read_clear();
    test_bus_errors();
    $display("checks: %0d, errors: %0d, cycles: %0d", check_count, error_count, cycle_count);
    if (error_count == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/gpio_apb_slave.sv
//----------------------------
// gpio apb slave
// turns apb phases into read and write
// strobes, routes prdata, flags pslverr
//----------------------------
`default_nettype none

module gpio_apb_slave (
  input  wire logic                                pclk25,
  input  wire logic                                n_reset25,
  input  wire logic                                psel,
  input  wire logic                                penable,
  input  wire logic                                pwrite,
  input  wire logic [gpio_pkg::addr_width-1:0]     paddr,
  input  wire logic [gpio_pkg::gpio_width-1:0]     pwdata,
  input  wire logic [gpio_pkg::gpio_width-1:0]     rdata,    // from pin unit
  output gpio_pkg::gpio_reg_req_t                  reg_req,
  output logic      [gpio_pkg::gpio_width-1:0]     prdata,
  output logic                                     pslverr
);

  logic setup_phase;   // psel high, penable low
  logic access_phase;  // psel and penable high
  logic addr_mapped;   // paddr hits one of the five registers
  logic addr_ro;       // input value or int status
  logic err_next;      // error decided in setup
  logic err_q;         // held into the access cycle

  assign setup_phase  = psel & ~penable;
  assign access_phase = psel & penable;

  //----------------------------
  // strobes
  //----------------------------
  // read goes early so the pin unit can register rdata
  // before the master samples prdata
  assign reg_req.read  = setup_phase & ~pwrite;
  assign reg_req.write = access_phase & pwrite;  // update at end of access
  assign reg_req.addr  = paddr;
  assign reg_req.wdata = pwdata;

  //----------------------------
  // address check
  //----------------------------
  always_comb
  begin
    addr_mapped = 1'b0;
    addr_ro     = 1'b0;
    case (paddr)
      gpio_pkg::gpr_direction_mode,
      gpio_pkg::gpr_output_enable,
      gpio_pkg::gpr_output_value:
        addr_mapped = 1'b1;
      gpio_pkg::gpr_input_value,
      gpio_pkg::gpr_int_status:
      begin
        addr_mapped = 1'b1;
        addr_ro     = 1'b1;  // writes here are errors
      end
      default:
        addr_mapped = 1'b0;  // hole in the map
    endcase
  end

  assign err_next = ~addr_mapped | (pwrite & addr_ro);

  // sample the error in setup, drop it otherwise
  always_ff @(posedge pclk25 or negedge n_reset25)
  begin
    if (!n_reset25)
      err_q <= 1'b0;
    else if (setup_phase)
      err_q <= err_next;
    else
      err_q <= 1'b0;
  end

  assign pslverr = err_q & access_phase;  // visible in access only

  //----------------------------
  // read data
  //----------------------------
  assign prdata = (access_phase & ~pwrite) ? rdata : '0;

  // master side protocol
  a_penable_needs_psel : assert property (
    @(posedge pclk25) disable iff (!n_reset25)
    $rose(penable) |-> psel
  );

  // address held over both phases of a transfer
  a_paddr_stable : assert property (
    @(posedge pclk25) disable iff (!n_reset25)
    setup_phase |=> $stable(paddr)
  );

endmodule

`default_nettype wire

//--- verilog/gpio_lite.sv
//----------------------------
// gpio lite top
// apb slave in front of the 16 pin unit
//----------------------------
`default_nettype none

module gpio_lite (
  input  wire logic                             pclk25,
  input  wire logic                             n_reset25,   // async, active low
  // apb, no pready
  input  wire logic                             psel,
  input  wire logic                             penable,
  input  wire logic                             pwrite,
  input  wire logic [gpio_pkg::addr_width-1:0]  paddr,
  input  wire logic [gpio_pkg::gpio_width-1:0]  pwdata,
  output logic      [gpio_pkg::gpio_width-1:0]  prdata,
  output logic                                  pslverr,
  // pins
  input  wire logic [gpio_pkg::gpio_width-1:0]  pin_in,
  input  wire logic [gpio_pkg::gpio_width-1:0]  tri_state_enable,
  output gpio_pkg::gpio_pad_t                   pad,
  output logic      [gpio_pkg::gpio_width-1:0]  interrupt
);

  //----------------------------
  // internal nets
  //----------------------------
  gpio_pkg::gpio_reg_req_t          reg_req;  // strobes, addr, wdata
  logic [gpio_pkg::gpio_width-1:0]  rdata;    // registered read data

  // bus side
  gpio_apb_slave apb0 (
    .pclk25    (pclk25),
    .n_reset25 (n_reset25),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .rdata     (rdata),
    .reg_req   (reg_req),
    .prdata    (prdata),
    .pslverr   (pslverr)
  );

  // pin side
  gpio_lite_subunit unit0 (
    .pclk25           (pclk25),
    .n_reset25        (n_reset25),
    .reg_req          (reg_req),
    .pin_in           (pin_in),
    .tri_state_enable (tri_state_enable),
    .rdata            (rdata),
    .pad              (pad),
    .interrupt        (interrupt)
  );

endmodule

`default_nettype wire

//--- verilog/gpio_lite_subunit.sv
//----------------------------
// gpio pin unit
// register file, input synchroniser,
// rising edge interrupt and pad drive
//----------------------------
`default_nettype none

module gpio_lite_subunit (
  input  wire logic                             pclk25,
  input  wire logic                             n_reset25,
  input  gpio_pkg::gpio_reg_req_t               reg_req,           // strobes from apb slave
  input  wire logic [gpio_pkg::gpio_width-1:0]  pin_in,            // raw pins, async
  input  wire logic [gpio_pkg::gpio_width-1:0]  tri_state_enable,  // test, forces drivers off
  output logic      [gpio_pkg::gpio_width-1:0]  rdata,
  output gpio_pkg::gpio_pad_t                   pad,
  output logic      [gpio_pkg::gpio_width-1:0]  interrupt
);

  //----------------------------
  // registers
  //----------------------------
  logic [gpio_pkg::gpio_width-1:0] direction_mode;  // 1 = input, 0 = output
  logic [gpio_pkg::gpio_width-1:0] output_enable;   // 1 = driver on
  logic [gpio_pkg::gpio_width-1:0] output_value;    // driven level
  logic [gpio_pkg::gpio_width-1:0] input_value;     // third sample stage
  logic [gpio_pkg::gpio_width-1:0] int_status;      // sticky edge flags

  // synchroniser stages
  logic [gpio_pkg::gpio_width-1:0] sync_one;  // first flop, sees the pin
  logic [gpio_pkg::gpio_width-1:0] sync_two;  // second flop, safe to use

  // edge detect
  logic [gpio_pkg::gpio_width-1:0] int_event;    // rising edge seen this cycle
  logic [gpio_pkg::gpio_width-1:0] int_trigger;  // edge on an input pin
  logic                            status_clear; // status read in progress

  // address decodes
  logic ad_direction_mode;
  logic ad_output_enable;
  logic ad_output_value;
  logic ad_int_status;

  assign ad_direction_mode = (reg_req.addr == gpio_pkg::gpr_direction_mode);
  assign ad_output_enable  = (reg_req.addr == gpio_pkg::gpr_output_enable);
  assign ad_output_value   = (reg_req.addr == gpio_pkg::gpr_output_value);
  assign ad_int_status     = (reg_req.addr == gpio_pkg::gpr_int_status);

  //----------------------------
  // control registers
  //----------------------------
  // written at the end of the access cycle
  always_ff @(posedge pclk25 or negedge n_reset25)
  begin
    if (!n_reset25)
    begin
      direction_mode <= gpio_pkg::gprv_direction_mode;
      output_enable  <= gpio_pkg::gprv_output_enable;
      output_value   <= gpio_pkg::gprv_output_value;
    end
    else if (reg_req.write)
    begin
      if (ad_direction_mode)
        direction_mode <= reg_req.wdata;
      if (ad_output_enable)
        output_enable <= reg_req.wdata;
      if (ad_output_value)
        output_value <= reg_req.wdata;
      // read only offsets and holes fall through, slave flags them
    end
  end

  //----------------------------
  // input synchroniser
  //----------------------------
  // pin_in -> sync_one -> sync_two -> input_value
  // three edges from pin to register
  always_ff @(posedge pclk25 or negedge n_reset25)
  begin
    if (!n_reset25)
    begin
      sync_one    <= '0;
      sync_two    <= '0;
      input_value <= '0;
    end
    else
    begin
      sync_one    <= pin_in;
      sync_two    <= sync_one;
      input_value <= sync_two;  // also the previous sample for edge detect
    end
  end

  //----------------------------
  // edge interrupt
  //----------------------------
  // new value high and last sample low
  assign int_event   = sync_two & ~input_value;
  assign int_trigger = int_event & direction_mode;  // outputs never interrupt

  // cleared by a status read in its setup cycle
  assign status_clear = reg_req.read & ad_int_status;

  always_ff @(posedge pclk25 or negedge n_reset25)
  begin
    if (!n_reset25)
      int_status <= gpio_pkg::gprv_int_status;
    else if (status_clear)
      int_status <= int_trigger;  // edge in the same cycle survives
    else
      int_status <= int_status | int_trigger;
  end

  assign interrupt = int_status;  // one line per pin

  //----------------------------
  // read data
  //----------------------------
  // latched on the read strobe, zero otherwise
  always_ff @(posedge pclk25 or negedge n_reset25)
  begin
    if (!n_reset25)
      rdata <= '0;
    else if (reg_req.read)
    begin
      case (reg_req.addr)
        gpio_pkg::gpr_direction_mode:
          rdata <= direction_mode;
        gpio_pkg::gpr_output_enable:
          rdata <= output_enable;
        gpio_pkg::gpr_output_value:
          rdata <= output_value;
        gpio_pkg::gpr_int_status:
          rdata <= int_status;   // value before the clear
        default:
          rdata <= input_value;  // input value and unmapped offsets
      endcase
    end
    else
      rdata <= '0;
  end

  //----------------------------
  // pad drive
  //----------------------------
  // drive only when enabled, set as output and not in test
  assign pad.pin_out  = output_value;
  assign pad.pin_oe_n = ~(output_enable & ~direction_mode) | tri_state_enable;

  // strobes come from the apb slave, one per transfer
  a_strobes_exclusive : assert property (
    @(posedge pclk25) disable iff (!n_reset25)
    !(reg_req.read && reg_req.write)
  );

endmodule

`default_nettype wire

//--- verilog/gpio_pkg.sv
//----------------------------
// gpio lite package
// register map, reset values, widths and
// the request and pad structs
//----------------------------
`default_nettype none

package gpio_pkg;

  //----------------------------
  // widths
  //----------------------------
  localparam int gpio_width = 16;  // pins in the block
  localparam int addr_width = 6;   // apb offset bits

  //----------------------------
  // register offsets
  //----------------------------
  // byte offsets on the apb side
  localparam logic [addr_width-1:0] gpr_direction_mode = 6'h04;  // 1 = input, 0 = output
  localparam logic [addr_width-1:0] gpr_output_enable  = 6'h08;  // per pin driver enable
  localparam logic [addr_width-1:0] gpr_output_value   = 6'h0C;  // value driven on pin_out
  localparam logic [addr_width-1:0] gpr_input_value    = 6'h10;  // sampled pins, read only
  localparam logic [addr_width-1:0] gpr_int_status     = 6'h20;  // rising edge flags, read only

  //----------------------------
  // reset values
  //----------------------------
  // all pins come up as outputs with drivers off
  localparam logic [gpio_width-1:0] gprv_direction_mode = '0;
  localparam logic [gpio_width-1:0] gprv_output_enable  = '0;  // drivers off
  localparam logic [gpio_width-1:0] gprv_output_value   = '0;
  localparam logic [gpio_width-1:0] gprv_int_status     = '0;  // no pending edges

  //----------------------------
  // structs
  //----------------------------

  // one cycle strobes from the bus side to the pin unit
  typedef struct packed {
    logic                  read;   // setup cycle of a read
    logic                  write;  // access cycle of a write
    logic [addr_width-1:0] addr;   // register offset
    logic [gpio_width-1:0] wdata;  // write data
  } gpio_reg_req_t;

  // pad side nets, kept apart from any bidir cell
  typedef struct packed {
    logic [gpio_width-1:0] pin_out;   // output value per pin
    logic [gpio_width-1:0] pin_oe_n;  // low drives the pin
  } gpio_pad_t;

endpackage

`default_nettype wire
